// File: src/dcachePkg.sv
package dcachePkg;

	// Cache geometry
	localparam int wordWidth = 32;
	localparam int numSets = 16;
	localparam int idxWidth = 4;
	// 32 minus index, block offset and byte offset bits
	localparam int tagWidth = 25;

	typedef logic [wordWidth-1:0] wordT;

	// Request address split
	typedef struct packed {
		logic [tagWidth-1:0] tag;
		logic [idxWidth-1:0] idx;
		logic blkOff;
		logic [1:0] bytOff;
	} dcacheAddrT;

	// Two-word cache block
	typedef struct packed {
		wordT wordA;
		wordT wordB;
	} blockT;

	typedef enum logic [3:0] {
		idle, readHit, overwrite, writeHit,
		writeBackA, writeBackB, fetchA, fetchB
	} cacheStateT;

endpackage

// File: src/cacheWay.sv
`timescale 1ns/1ps

module cacheWay (
	input logic CLK,
	input logic nRST,
	input dcachePkg::dcacheAddrT reqAddr,
	input logic fill,
	input logic write,
	input logic clean,
	input logic wordSel,
	input dcachePkg::wordT fillData,
	input dcachePkg::wordT storeData,
	output logic hit,
	output logic valid,
	output logic dirty,
	output logic [dcachePkg::tagWidth-1:0] storedTag,
	output dcachePkg::wordT readWord,
	output dcachePkg::blockT block
);
	import dcachePkg::*;

	// One entry per set
	logic [tagWidth-1:0] tagArr [numSets];
	blockT dataArr [numSets];
	logic [numSets-1:0] validBits;
	logic [numSets-1:0] dirtyBits;

	// Lookup at the request index
	assign valid = validBits[reqAddr.idx];
	assign dirty = dirtyBits[reqAddr.idx];
	assign storedTag = tagArr[reqAddr.idx];
	assign block = dataArr[reqAddr.idx];
	assign hit = valid && (storedTag == reqAddr.tag);

	// Word within the block picked by the block offset
	assign readWord = reqAddr.blkOff ? block.wordB : block.wordA;

	// Entry flags
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			validBits <= '0;
			dirtyBits <= '0;
		end else begin
			if (fill) begin
				// Refilled words match memory
				validBits[reqAddr.idx] <= 1'b1;
				dirtyBits[reqAddr.idx] <= 1'b0;
			end else if (write) begin
				dirtyBits[reqAddr.idx] <= 1'b1;
			end else if (clean) begin
				dirtyBits[reqAddr.idx] <= 1'b0;
			end
		end
	end

	// Tag and block storage
	always_ff @(posedge CLK) begin
		if (fill) begin
			tagArr[reqAddr.idx] <= reqAddr.tag;
			if (wordSel) begin
				dataArr[reqAddr.idx].wordB <= fillData;
			end else begin
				dataArr[reqAddr.idx].wordA <= fillData;
			end
		end else if (write) begin
			// Requester's store lands at its own word
			if (reqAddr.blkOff) begin
				dataArr[reqAddr.idx].wordB <= storeData;
			end else begin
				dataArr[reqAddr.idx].wordA <= storeData;
			end
		end
	end

endmodule

// File: src/lruTable.sv
`timescale 1ns/1ps

module lruTable (
	input logic CLK,
	input logic nRST,
	input logic [dcachePkg::idxWidth-1:0] idx,
	input logic update,
	input logic usedWay,
	input logic validZero,
	input logic validOne,
	output logic victimWay
);
	import dcachePkg::*;

	// Last way used in each set
	logic [numSets-1:0] recUsed;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			recUsed <= '0;
		end else if (update) begin
			recUsed[idx] <= usedWay;
		end
	end

	// Invalid ways are taken first with way 0 ahead of way 1
	always_comb begin
		if (!validZero) begin
			victimWay = 1'b0;
		end else if (!validOne) begin
			victimWay = 1'b1;
		end else begin
			victimWay = ~recUsed[idx];
		end
	end

endmodule

// File: src/cacheController.sv
`timescale 1ns/1ps

module cacheController (
	input logic CLK,
	input logic nRST,
	input logic dmemREN,
	input logic dmemWEN,
	input dcachePkg::wordT dmemAddr,
	output logic dhit,
	output dcachePkg::wordT dmemLoad,
	input logic hitZero,
	input logic hitOne,
	input logic dirtyZero,
	input logic dirtyOne,
	input logic [dcachePkg::tagWidth-1:0] tagZero,
	input logic [dcachePkg::tagWidth-1:0] tagOne,
	input dcachePkg::wordT wordZero,
	input dcachePkg::wordT wordOne,
	input dcachePkg::blockT blockZero,
	input dcachePkg::blockT blockOne,
	input logic victimWay,
	output logic fillZero,
	output logic fillOne,
	output logic writeZero,
	output logic writeOne,
	output logic cleanZero,
	output logic cleanOne,
	output logic wordSel,
	output logic lruUpdate,
	output logic usedWay,
	output logic memREN,
	output logic memWEN,
	input logic memWait,
	output dcachePkg::wordT memAddr,
	output dcachePkg::wordT memStore
);
	import dcachePkg::*;

	cacheStateT state, nextState;
	dcacheAddrT reqAddr;
	dcacheAddrT xferAddr;
	blockT victimBlock;
	logic [tagWidth-1:0] victimTag;
	logic anyHit, victimDirty, targetWay, fill, clean;

	assign reqAddr = dcacheAddrT'(dmemAddr);
	assign anyHit = hitZero || hitOne;
	assign victimDirty = victimWay ? dirtyOne : dirtyZero;

	// Target way is fixed once the request leaves idle
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state <= idle;
			targetWay <= 1'b0;
		end else begin
			state <= nextState;
			if (state == idle) begin
				targetWay <= hitOne ? 1'b1 : (hitZero ? 1'b0 : victimWay);
			end
		end
	end

	always_comb begin
		nextState = state;
		case (state)
			idle: begin
				if (dmemREN || dmemWEN) begin
					if (anyHit) begin
						nextState = dmemWEN ? overwrite : readHit;
					end else begin
						nextState = victimDirty ? writeBackA : fetchA;
					end
				end
			end
			overwrite: nextState = writeHit;
			readHit, writeHit: nextState = idle;
			writeBackA: if (!memWait) nextState = writeBackB;
			writeBackB: if (!memWait) nextState = fetchA;
			fetchA: if (!memWait) nextState = fetchB;
			fetchB: if (!memWait) nextState = dmemWEN ? overwrite : idle;
			default: nextState = idle;
		endcase
	end

	// Victim contents for write-back
	assign victimTag = targetWay ? tagOne : tagZero;
	assign victimBlock = targetWay ? blockOne : blockZero;

	// Block-aligned word pair with the victim's tag during write-back
	always_comb begin
		xferAddr = reqAddr;
		xferAddr.bytOff = 2'b00;
		xferAddr.blkOff = (state == writeBackB) || (state == fetchB);
		if ((state == writeBackA) || (state == writeBackB)) begin
			xferAddr.tag = victimTag;
		end
	end

	assign memWEN = (state == writeBackA) || (state == writeBackB);
	assign memREN = (state == fetchA) || (state == fetchB);
	assign memAddr = (memREN || memWEN) ? wordT'(xferAddr) : '0;
	assign memStore = (state == writeBackB) ? victimBlock.wordB : victimBlock.wordA;

	// Way updates only on a completed transfer
	assign fill = memREN && !memWait;
	assign clean = (state == writeBackB) && !memWait;
	assign wordSel = (state == fetchB);
	assign fillZero = fill && !targetWay;
	assign fillOne = fill && targetWay;
	assign cleanZero = clean && !targetWay;
	assign cleanOne = clean && targetWay;
	assign writeZero = (state == overwrite) && !targetWay;
	assign writeOne = (state == overwrite) && targetWay;

	// Datapath response
	assign dhit = (state == readHit) || (state == writeHit);
	assign dmemLoad = (state == readHit) ? (targetWay ? wordOne : wordZero) : '0;
	assign lruUpdate = dhit;
	assign usedWay = targetWay;

endmodule

// File: src/dcacheTop.sv
`timescale 1ns/1ps

module dcacheTop (
	input logic CLK,
	input logic nRST,
	input logic dmemREN,
	input logic dmemWEN,
	input dcachePkg::wordT dmemAddr,
	input dcachePkg::wordT dmemStore,
	output logic dhit,
	output dcachePkg::wordT dmemLoad,
	output logic memREN,
	output logic memWEN,
	input logic memWait,
	output dcachePkg::wordT memAddr,
	output dcachePkg::wordT memStore,
	input dcachePkg::wordT memLoad
);
	import dcachePkg::*;

	dcacheAddrT reqAddr;
	logic hitZero, hitOne, validZero, validOne, dirtyZero, dirtyOne;
	logic [tagWidth-1:0] tagZero, tagOne;
	wordT wordZero, wordOne;
	blockT blockZero, blockOne;
	logic fillZero, fillOne, writeZero, writeOne, cleanZero, cleanOne, wordSel;
	logic lruUpdate, usedWay, victimWay;

	assign reqAddr = dcacheAddrT'(dmemAddr);

	cacheWay wayZero (
		.CLK, .nRST, .reqAddr, .fill(fillZero), .write(writeZero), .clean(cleanZero),
		.wordSel, .fillData(memLoad), .storeData(dmemStore), .hit(hitZero),
		.valid(validZero), .dirty(dirtyZero), .storedTag(tagZero),
		.readWord(wordZero), .block(blockZero)
	);

	cacheWay wayOne (
		.CLK, .nRST, .reqAddr, .fill(fillOne), .write(writeOne), .clean(cleanOne),
		.wordSel, .fillData(memLoad), .storeData(dmemStore), .hit(hitOne),
		.valid(validOne), .dirty(dirtyOne), .storedTag(tagOne),
		.readWord(wordOne), .block(blockOne)
	);

	lruTable lru (
		.CLK, .nRST, .idx(reqAddr.idx), .update(lruUpdate), .usedWay,
		.validZero, .validOne, .victimWay
	);

	cacheController ctrl (
		.CLK, .nRST, .dmemREN, .dmemWEN, .dmemAddr, .dhit, .dmemLoad,
		.hitZero, .hitOne, .dirtyZero, .dirtyOne, .tagZero, .tagOne,
		.wordZero, .wordOne, .blockZero, .blockOne, .victimWay,
		.fillZero, .fillOne, .writeZero, .writeOne, .cleanZero, .cleanOne,
		.wordSel, .lruUpdate, .usedWay,
		.memREN, .memWEN, .memWait, .memAddr, .memStore
	);

endmodule

// File: verification/dcacheAssertions.sv
`timescale 1ns/1ps

module dcacheAssertions (
	input logic CLK,
	input logic nRST,
	input logic dhit,
	input logic memREN,
	input logic memWEN,
	input dcachePkg::wordT memAddr
);
	int failCount = 0;

	// One memory direction at a time
	noDualRequest: assert property (@(posedge CLK) disable iff (!nRST) !(memREN && memWEN))
		else begin
			$error("memREN and memWEN are high in the same cycle");
			failCount++;
		end

	// dhit is a single-cycle pulse
	singleHitPulse: assert property (@(posedge CLK) disable iff (!nRST) dhit |=> !dhit)
		else begin
			$error("dhit stayed high for two cycles");
			failCount++;
		end

	// Memory side only sees word addresses
	wordAlignedXfer: assert property (@(posedge CLK) disable iff (!nRST)
		(memREN || memWEN) |-> (memAddr[1:0] == 2'b00))
		else begin
			$error("memAddr has a nonzero byte offset during a transfer");
			failCount++;
		end

endmodule

// File: verification/dcacheTb.sv
`timescale 1ns/1ps

module dcacheTb;
	import dcachePkg::*;

	typedef struct packed {
		logic isWrite;
		wordT addr;
		wordT data;
		int expWrites;
	} stepT;

	typedef struct packed {
		logic isWrite;
		wordT addr;
		wordT data;
	} xferT;

	localparam int numSteps = 18;
	localparam int timeoutCycles = numSteps * 40;

	logic CLK, nRST, dmemREN, dmemWEN, dhit, memREN, memWEN, memWait;
	wordT dmemAddr, dmemStore, dmemLoad, memAddr, memStore, memLoad;

	// Shadow of memory and of the cache state
	wordT shadowMem [wordT];
	logic [tagWidth-1:0] shTag [numSets][2];
	logic [1:0] shValid [numSets];
	logic [1:0] shDirty [numSets];
	logic [numSets-1:0] shUsed;
	xferT expQ [$];

	// Memory model storage
	wordT memArr [wordT];
	int seed = 32'h6159;
	int writesSeen, cycleCount, waitLeft;
	logic busy;

	// Operation, address, store data, memory writes expected
	stepT steps [numSteps] = '{
		'{1'b0, 32'h0000_0094, 32'h0000_0000, 0},
		'{1'b0, 32'h0000_0090, 32'h0000_0000, 0},
		'{1'b1, 32'h0000_0094, 32'hDEAD_0001, 0},
		'{1'b0, 32'h0000_0094, 32'h0000_0000, 0},
		'{1'b0, 32'h0000_0110, 32'h0000_0000, 0},
		'{1'b0, 32'h0000_0190, 32'h0000_0000, 2},
		'{1'b0, 32'h0000_0110, 32'h0000_0000, 0},
		'{1'b0, 32'h0000_0094, 32'h0000_0000, 0},
		'{1'b1, 32'h0000_0214, 32'hBEEF_0002, 0},
		'{1'b0, 32'h0000_0190, 32'h0000_0000, 0},
		'{1'b0, 32'h0000_0110, 32'h0000_0000, 2},
		'{1'b0, 32'h0000_0214, 32'h0000_0000, 0},
		'{1'b1, 32'h0000_0A3C, 32'hC0FF_EE03, 0},
		'{1'b0, 32'h0000_0A38, 32'h0000_0000, 0},
		'{1'b0, 32'h0000_0A3E, 32'h0000_0000, 0},
		'{1'b0, 32'hFFFF_FFF8, 32'h0000_0000, 0},
		'{1'b1, 32'hFFFF_FFFC, 32'h1234_5678, 0},
		'{1'b0, 32'hFFFF_FFFC, 32'h0000_0000, 0}
	};

	dcacheTop UUT (
		.CLK, .nRST, .dmemREN, .dmemWEN, .dmemAddr, .dmemStore, .dhit, .dmemLoad,
		.memREN, .memWEN, .memWait, .memAddr, .memStore, .memLoad
	);

	bind cacheController dcacheAssertions chk (
		.CLK(CLK), .nRST(nRST), .dhit(dhit),
		.memREN(memREN), .memWEN(memWEN), .memAddr(memAddr)
	);

	// Power-on memory contents
	function automatic wordT initialWord(input wordT addr);
		return addr * 32'h9E37_79B1 + 32'h1357_9BDF;
	endfunction

	function automatic wordT expectedWord(input wordT addr);
		wordT aligned;
		aligned = {addr[31:2], 2'b00};
		return shadowMem.exists(aligned) ? shadowMem[aligned] : initialWord(aligned);
	endfunction

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("TEST RESULT: FAIL");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic compareWord(input string name, input wordT actual, input wordT expected);
		if (actual !== expected) begin
			abortRun($sformatf("FAILED at %0t: %s expected %h, got %h",
				$time, name, expected, actual));
		end
	endtask

	task automatic compareAddr(input string name, input dcacheAddrT actual,
		input dcacheAddrT expected);
		if (actual !== expected) begin
			abortRun($sformatf("FAILED at %0t: %s expected %h (set %0d), got %h (set %0d)",
				$time, name, expected, expected.idx, actual, actual.idx));
		end
	endtask

	task automatic expectXfer(input logic isWrite, input wordT addr);
		expQ.push_back(xferT'{isWrite, addr, expectedWord(addr)});
	endtask

	// One access through the shadow model, queueing the memory traffic it implies
	task automatic predictStep(input stepT s, output logic isHit);
		dcacheAddrT a;
		logic way;
		wordT base;
		a = dcacheAddrT'(s.addr);
		isHit = 1'b0;
		way = 1'b0;
		for (int w = 0; w < 2; w++) begin
			if (shValid[a.idx][w] && shTag[a.idx][w] == a.tag) begin
				isHit = 1'b1;
				way = w[0];
			end
		end
		if (!isHit) begin
			// Invalid way first or else the one not recently used
			way = !shValid[a.idx][0] ? 1'b0 : (!shValid[a.idx][1] ? 1'b1 : !shUsed[a.idx]);
			if (shValid[a.idx][way] && shDirty[a.idx][way]) begin
				base = {shTag[a.idx][way], a.idx, 3'b000};
				expectXfer(1'b1, base);
				expectXfer(1'b1, base + 32'd4);
			end
			base = {a.tag, a.idx, 3'b000};
			expectXfer(1'b0, base);
			expectXfer(1'b0, base + 32'd4);
			shTag[a.idx][way] = a.tag;
			shValid[a.idx][way] = 1'b1;
			shDirty[a.idx][way] = 1'b0;
		end
		if (s.isWrite) begin
			shDirty[a.idx][way] = 1'b1;
			shadowMem[{s.addr[31:2], 2'b00}] = s.data;
		end
		shUsed[a.idx] = way;
	endtask

	task automatic runStep(input stepT s);
		logic isHit;
		int latency;
		predictStep(s, isHit);
		writesSeen = 0;
		dmemREN = !s.isWrite;
		dmemWEN = s.isWrite;
		dmemAddr = s.addr;
		dmemStore = s.data;
		latency = 0;
		do begin
			@(negedge CLK);
			latency++;
		end while (!dhit);
		if (!s.isWrite) begin
			compareWord("dmemLoad", dmemLoad, expectedWord(s.addr));
		end
		// Hits answer in fixed time
		if (isHit && latency != (s.isWrite ? 2 : 1)) begin
			abortRun($sformatf("FAILED at %0t: dhit latency expected %0d, got %0d",
				$time, s.isWrite ? 2 : 1, latency));
		end
		if (expQ.size() != 0) begin
			abortRun($sformatf("Access to %h ended with %0d memory transfers not done",
				s.addr, expQ.size()));
		end
		if (writesSeen != s.expWrites) begin
			abortRun($sformatf("FAILED at %0t: memory write count expected %0d, got %0d",
				$time, s.expWrites, writesSeen));
		end
		// Request stays up through the dhit cycle
		@(negedge CLK);
	endtask

	// Transfer completes at the next rising edge
	task automatic finishTransfer;
		xferT x;
		if (expQ.size() == 0) begin
			abortRun($sformatf("Unexpected memory transfer to %h at %0t", memAddr, $time));
		end
		x = expQ.pop_front();
		compareWord("memWEN", wordT'(memWEN), wordT'(x.isWrite));
		compareAddr("memAddr", dcacheAddrT'(memAddr), dcacheAddrT'(x.addr));
		if (memWEN) begin
			compareWord("memStore", memStore, x.data);
			memArr[memAddr] = memStore;
			writesSeen++;
		end else begin
			memLoad = memArr.exists(memAddr) ? memArr[memAddr] : initialWord(memAddr);
		end
	endtask

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	// Memory with 0 to 3 wait cycles per transfer
	initial begin
		memWait = 1'b0;
		memLoad = '0;
		busy = 1'b0;
		waitLeft = 0;
		forever begin
			@(negedge CLK);
			if (memREN || memWEN) begin
				if (!busy) begin
					busy = 1'b1;
					waitLeft = $random(seed) & 3;
				end
				if (waitLeft == 0) begin
					memWait = 1'b0;
					finishTransfer();
					busy = 1'b0;
				end else begin
					memWait = 1'b1;
					waitLeft--;
				end
			end else begin
				memWait = 1'b0;
			end
		end
	end

	initial begin
		cycleCount = 0;
		forever begin
			@(posedge CLK);
			cycleCount++;
			if (cycleCount > timeoutCycles) begin
				abortRun($sformatf("Timeout after %0d cycles without finishing", cycleCount));
			end
		end
	end

	initial begin
		nRST = 1'b0;
		dmemREN = 1'b0;
		dmemWEN = 1'b0;
		dmemAddr = '0;
		dmemStore = '0;
		shUsed = '0;
		for (int i = 0; i < numSets; i++) begin
			shValid[i] = 2'b00;
			shDirty[i] = 2'b00;
		end
		repeat (4) @(negedge CLK);
		nRST = 1'b1;
		compareWord("dhit", wordT'(dhit), '0);
		compareWord("memREN", wordT'(memREN), '0);
		compareWord("memWEN", wordT'(memWEN), '0);
		for (int i = 0; i < numSteps; i++) begin
			runStep(steps[i]);
		end
		dmemREN = 1'b0;
		dmemWEN = 1'b0;
		repeat (2) @(negedge CLK);
		if (UUT.ctrl.chk.failCount == 0) begin
			$display("TEST RESULT: PASS");
			$finish;
		end else begin
			abortRun("Handshake assertions failed during the run");
		end
	end

endmodule

// File: dcacheTop.f
src/dcachePkg.sv
src/cacheWay.sv
src/lruTable.sv
src/cacheController.sv
src/dcacheTop.sv
verification/dcacheAssertions.sv
verification/dcacheTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= dcacheTb
FILELIST ?= dcacheTop.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST RESULT: PASS" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
